// ==== compile.f ====
src/cpu_pkg.sv
src/alu.sv
src/reg_file.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/execute_unit.sv
src/pipeline_control.sv
src/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam cpu_pkg::word_t RESET_PC = 32'h0000_0000;
	localparam int RETIRE_TARGET = 2000;
	localparam int CYCLE_LIMIT = 40 * RETIRE_TARGET + 200;

	logic               clk;
	logic               rst;
	logic               inst_req_valid;
	cpu_pkg::word_t     inst_req_pc;
	logic               inst_req_ready;
	logic               inst_resp_valid;
	cpu_pkg::word_t     inst_resp_data;
	logic               inst_resp_ready;
	logic               retire_valid;
	logic               retire_wen;
	cpu_pkg::reg_addr_t retire_waddr;
	cpu_pkg::word_t     retire_wdata;
	cpu_pkg::word_t     retire_pc;

	cpu_pkg::word_t prog [256];
	logic           prog_loaded;
	logic           timed_out;
	logic           run_done;
	int             retired;
	int             error_total;
	int             cycles;
	int             req_gap;
	int             resp_gap;
	int             draw;
	cpu_pkg::word_t pending_pc [$];
	cpu_pkg::word_t served_pc;

	function automatic cpu_pkg::word_t r_format(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, cpu_pkg::OP};
	endfunction

	function automatic cpu_pkg::word_t i_format(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic cpu_pkg::word_t branch_word(input logic [12:0] off,
			input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::BRANCH};
	endfunction

	function automatic cpu_pkg::word_t jump_word(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::JAL};
	endfunction

	// dense x0..x7 use keeps dependencies back to back
	function automatic logic [4:0] pick_reg();
		return 5'($urandom % 8);
	endfunction

	// nonzero word offset in -4..7
	function automatic int pick_offset();
		int off;
		off = int'($urandom % 12) - 4;
		if (off == 0) begin
			off = 1;
		end
		return off;
	endfunction

	task automatic build_program();
		int i;
		int kind;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		for (i = 0; i < 256; i++) begin
			f3 = 3'($urandom % 8);
			imm = 12'($urandom);
			kind = int'($urandom % 20);
			if (i < 7) begin
				// give x1..x7 known values before anything reads them
				prog[i] = i_format(imm, 5'd0, 3'b000, 5'(i + 1), cpu_pkg::OP_IMM);
			end else if (kind < 7) begin
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
				prog[i] = r_format(f7, pick_reg(), pick_reg(), f3, pick_reg());
			end else if (kind < 11) begin
				if (f3 == 3'd1) begin
					imm[11:5] = 7'h00;
				end else if (f3 == 3'd5) begin
					imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
				end
				prog[i] = i_format(imm, pick_reg(), f3, pick_reg(), cpu_pkg::OP_IMM);
			end else if (kind == 11) begin
				prog[i] = {20'($urandom), pick_reg(), cpu_pkg::LUI};
			end else if (kind == 12) begin
				prog[i] = {20'($urandom), pick_reg(), cpu_pkg::AUIPC};
			end else if (kind < 16) begin
				// 010 and 011 are not branch encodings
				if (f3 == 3'd2 || f3 == 3'd3) begin
					f3 = f3 + 3'd2;
				end
				prog[i] = branch_word(13'(pick_offset() * 4), pick_reg(), pick_reg(), f3);
			end else if (kind == 16) begin
				prog[i] = jump_word(21'(pick_offset() * 4), pick_reg());
			end else if (kind == 18) begin
				// loads retire as no-ops on this core
				prog[i] = i_format(imm, pick_reg(), 3'b010, pick_reg(), 7'b0000011);
			end else begin
				prog[i] = i_format(12'($urandom % 64), pick_reg(), 3'b000, pick_reg(),
					cpu_pkg::JALR);
			end
		end
	endtask

	cpu_top #(
		.RESET_PC (RESET_PC)
	) cpu_top_inst (
		.clk             (clk),
		.rst             (rst),
		.inst_req_valid  (inst_req_valid),
		.inst_req_pc     (inst_req_pc),
		.inst_req_ready  (inst_req_ready),
		.inst_resp_valid (inst_resp_valid),
		.inst_resp_data  (inst_resp_data),
		.inst_resp_ready (inst_resp_ready),
		.retire_valid    (retire_valid),
		.retire_wen      (retire_wen),
		.retire_waddr    (retire_waddr),
		.retire_wdata    (retire_wdata),
		.retire_pc       (retire_pc)
	);

	cpu_checker #(
		.RESET_PC (RESET_PC)
	) cpu_checker_inst (
		.clk          (clk),
		.rst          (rst),
		.prog_loaded  (prog_loaded),
		.prog         (prog),
		.retire_valid (retire_valid),
		.retire_wen   (retire_wen),
		.retire_waddr (retire_waddr),
		.retire_wdata (retire_wdata),
		.retire_pc    (retire_pc),
		.timed_out    (timed_out),
		.run_done     (run_done),
		.retire_count (retired),
		.error_total  (error_total)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	// instruction memory with random stalls on both channels
	always @(posedge clk) begin
		if (rst) begin
			inst_req_ready <= 1'b0;
			inst_resp_valid <= 1'b0;
			req_gap <= 0;
			resp_gap <= 0;
			pending_pc.delete();
		end else begin
			if (inst_req_valid && inst_req_ready) begin
				pending_pc.push_back(inst_req_pc);
				draw = int'($urandom % 4);
				req_gap <= draw;
				inst_req_ready <= (draw == 0);
			end else if (!inst_req_ready) begin
				if (req_gap <= 1) begin
					inst_req_ready <= 1'b1;
				end else begin
					req_gap <= req_gap - 1;
				end
			end
			if (inst_resp_valid && inst_resp_ready) begin
				inst_resp_valid <= 1'b0;
				resp_gap <= int'($urandom % 4);
			end else if (!inst_resp_valid && pending_pc.size() > 0) begin
				if (resp_gap == 0) begin
					served_pc = pending_pc.pop_front();
					inst_resp_valid <= 1'b1;
					inst_resp_data <= prog[served_pc[9:2]];
				end else begin
					resp_gap <= resp_gap - 1;
				end
			end
		end
	end

	initial begin
		rst = 1'b1;
		inst_req_ready = 1'b0;
		inst_resp_valid = 1'b0;
		inst_resp_data = '0;
		prog_loaded = 1'b0;
		timed_out = 1'b0;
		run_done = 1'b0;
		void'($urandom(32'he0fa));
		build_program();
		prog_loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		while (retired < RETIRE_TARGET && cycles < CYCLE_LIMIT) begin
			@(posedge clk);
		end
		// let the last retire settle in the checker
		@(negedge clk);
		if (retired < RETIRE_TARGET) begin
			timed_out = 1'b1;
			$display("no progress: only %0d of %0d instructions retired within %0d cycles",
				retired, RETIRE_TARGET, CYCLE_LIMIT);
		end
		run_done = 1'b1;
		#1;
		if (error_total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               prog_loaded,
	input  cpu_pkg::word_t     prog [256],
	input  logic               retire_valid,
	input  logic               retire_wen,
	input  cpu_pkg::reg_addr_t retire_waddr,
	input  cpu_pkg::word_t     retire_wdata,
	input  cpu_pkg::word_t     retire_pc,
	input  logic               timed_out,
	input  logic               run_done,
	output int                 retire_count,
	output int                 error_total
);

	cpu_pkg::word_t mem [256];
	cpu_pkg::word_t regs [32];
	cpu_pkg::word_t pc;
	int             value_errors = 0;
	int             flow_errors = 0;
	int             write_errors = 0;

	assign error_total = value_errors + flow_errors + write_errors + (timed_out ? 1 : 0);

	initial begin
		int i;
		wait (prog_loaded);
		for (i = 0; i < 256; i++) begin
			mem[i] = prog[i];
		end
	end

	// RV32I integer semantics, shift amount from the low five bits
	function automatic cpu_pkg::word_t rv_alu(input logic [2:0] f3, input logic alt,
			input cpu_pkg::word_t a, input cpu_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input cpu_pkg::word_t a,
			input cpu_pkg::word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	always @(posedge clk) begin
		cpu_pkg::word_t instr;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t imm_i;
		cpu_pkg::word_t imm_b;
		cpu_pkg::word_t imm_u;
		cpu_pkg::word_t imm_j;
		cpu_pkg::word_t result;
		cpu_pkg::word_t next_pc;
		logic [2:0]     f3;
		logic           wen;
		string          name;
		int             i;
		if (rst) begin
			pc = RESET_PC;
			for (i = 0; i < 32; i++) begin
				regs[i] = '0;
			end
			retire_count <= 0;
		end else if (retire_valid) begin
			instr = mem[pc[9:2]];
			f3 = instr[14:12];
			a = regs[instr[19:15]];
			b = regs[instr[24:20]];
			imm_i = {{20{instr[31]}}, instr[31:20]};
			imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			imm_u = {instr[31:12], 12'h000};
			imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			next_pc = pc + 32'd4;
			wen = 1'b1;
			result = '0;
			name = "alu_result";
			case (instr[6:0])
				cpu_pkg::OP: begin
					result = rv_alu(f3, instr[30], a, b);
				end
				cpu_pkg::OP_IMM: begin
					result = rv_alu(f3, f3 == 3'd5 && instr[30], a, imm_i);
				end
				cpu_pkg::LUI: begin
					result = imm_u;
					name = "upper_immediate";
				end
				cpu_pkg::AUIPC: begin
					result = pc + imm_u;
					name = "upper_immediate";
				end
				cpu_pkg::BRANCH: begin
					wen = 1'b0;
					if (branch_taken(f3, a, b)) begin
						next_pc = pc + imm_b;
					end
				end
				cpu_pkg::JAL: begin
					result = pc + 32'd4;
					name = "link_value";
					next_pc = (pc + imm_j) & ~32'd3;
				end
				cpu_pkg::JALR: begin
					result = pc + 32'd4;
					name = "link_value";
					next_pc = (a + imm_i) & ~32'd3;
				end
				default: begin
					// unsupported encoding, no architectural effect
					wen = 1'b0;
				end
			endcase
			if (retire_pc !== pc) begin
				$display("ERR control_flow: expected %h, actual %h", pc, retire_pc);
				flow_errors++;
			end
			if (retire_wen !== wen) begin
				$display("ERR write_enable at pc %h: expected %0b, actual %0b",
					pc, wen, retire_wen);
				write_errors++;
			end else if (wen) begin
				if (retire_waddr !== instr[11:7]) begin
					$display("ERR write_address at pc %h: expected %0d, actual %0d",
						pc, instr[11:7], retire_waddr);
					write_errors++;
				end
				if (retire_wdata !== result) begin
					$display("ERR %s at pc %h: expected %h, actual %h",
						name, pc, result, retire_wdata);
					value_errors++;
				end
			end
			// x0 stays zero in the model
			if (wen && instr[11:7] != 5'd0) begin
				regs[instr[11:7]] = result;
			end
			pc = next_pc;
			retire_count <= retire_count + 1;
		end
	end

	initial begin
		wait (run_done);
		$display("errors: value %0d, control flow %0d, write port %0d, progress %0d; %0d retired",
			value_errors, flow_errors, write_errors, timed_out ? 1 : 0, retire_count);
	end

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	output logic               inst_req_valid,
	output cpu_pkg::word_t     inst_req_pc,
	input  logic               inst_req_ready,
	input  logic               inst_resp_valid,
	input  cpu_pkg::word_t     inst_resp_data,
	output logic               inst_resp_ready,
	output logic               retire_valid,
	output logic               retire_wen,
	output cpu_pkg::reg_addr_t retire_waddr,
	output cpu_pkg::word_t     retire_wdata,
	output cpu_pkg::word_t     retire_pc
);

	logic               inst_held;
	logic               advance;
	logic               flush;
	logic               fwd_a;
	logic               fwd_b;
	logic               redirect;
	cpu_pkg::word_t     redirect_pc;
	cpu_pkg::word_t     fetch_pc;
	cpu_pkg::word_t     fetch_instr;
	cpu_pkg::reg_addr_t rs1;
	cpu_pkg::reg_addr_t rs2;
	logic               dec_valid;
	cpu_pkg::word_t     dec_pc;
	cpu_pkg::word_t     dec_imm;
	cpu_pkg::reg_addr_t dec_rd;
	cpu_pkg::op_class_e dec_class;
	cpu_pkg::alu_op_e   dec_alu_op;
	logic [2:0]         dec_funct3;
	cpu_pkg::word_t     rdata1;
	cpu_pkg::word_t     rdata2;
	cpu_pkg::reg_addr_t ex_rs1;
	cpu_pkg::reg_addr_t ex_rs2;

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) fetch_unit_inst (
		.clk             (clk),
		.rst             (rst),
		.advance         (advance),
		.redirect        (redirect),
		.redirect_pc     (redirect_pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_pc     (inst_req_pc),
		.inst_req_ready  (inst_req_ready),
		.inst_resp_valid (inst_resp_valid),
		.inst_resp_data  (inst_resp_data),
		.inst_resp_ready (inst_resp_ready),
		.inst_held       (inst_held),
		.fetch_pc        (fetch_pc),
		.fetch_instr     (fetch_instr)
	);

	inst_decoder inst_decoder_inst (
		.clk         (clk),
		.rst         (rst),
		.advance     (advance),
		.flush       (flush),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr),
		.rs1         (rs1),
		.rs2         (rs2),
		.dec_valid   (dec_valid),
		.dec_pc      (dec_pc),
		.dec_imm     (dec_imm),
		.dec_rd      (dec_rd),
		.dec_class   (dec_class),
		.dec_alu_op  (dec_alu_op),
		.dec_funct3  (dec_funct3)
	);

	// write port fed straight from the write-back register
	reg_file reg_file_inst (
		.clk    (clk),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.waddr  (retire_waddr),
		.wen    (retire_wen),
		.wdata  (retire_wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	execute_unit execute_unit_inst (
		.clk         (clk),
		.rst         (rst),
		.advance     (advance),
		.flush       (flush),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.dec_valid   (dec_valid),
		.dec_pc      (dec_pc),
		.dec_imm     (dec_imm),
		.dec_rd      (dec_rd),
		.dec_class   (dec_class),
		.dec_alu_op  (dec_alu_op),
		.dec_funct3  (dec_funct3),
		.rs1         (rs1),
		.rs2         (rs2),
		.rdata1      (rdata1),
		.rdata2      (rdata2),
		.ex_rs1      (ex_rs1),
		.ex_rs2      (ex_rs2),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_valid    (retire_valid),
		.wb_wen      (retire_wen),
		.wb_rd       (retire_waddr),
		.wb_data     (retire_wdata),
		.wb_pc       (retire_pc)
	);

	pipeline_control pipeline_control_inst (
		.inst_held (inst_held),
		.redirect  (redirect),
		.ex_rs1    (ex_rs1),
		.ex_rs2    (ex_rs2),
		.wb_wen    (retire_wen),
		.wb_rd     (retire_waddr),
		.advance   (advance),
		.flush     (flush),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b)
	);

endmodule

`default_nettype wire

// ==== src/pipeline_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
	input  logic               inst_held,
	input  logic               redirect,
	input  cpu_pkg::reg_addr_t ex_rs1,
	input  cpu_pkg::reg_addr_t ex_rs2,
	input  logic               wb_wen,
	input  cpu_pkg::reg_addr_t wb_rd,
	output logic               advance,
	output logic               flush,
	output logic               fwd_a,
	output logic               fwd_b
);

	logic wb_live;

	// no data stalls without loads, so fetch alone paces the pipe
	assign advance = inst_held;

	// the two younger slots are on the wrong path
	assign flush = advance && redirect;

	// x0 never forwards
	assign wb_live = wb_wen && (wb_rd != 5'd0);

	assign fwd_a = wb_live && (wb_rd == ex_rs1);
	assign fwd_b = wb_live && (wb_rd == ex_rs2);

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  logic               clk,
	input  logic               rst,
	input  logic               advance,
	input  logic               flush,
	input  logic               fwd_a,
	input  logic               fwd_b,
	input  logic               dec_valid,
	input  cpu_pkg::word_t     dec_pc,
	input  cpu_pkg::word_t     dec_imm,
	input  cpu_pkg::reg_addr_t dec_rd,
	input  cpu_pkg::op_class_e dec_class,
	input  cpu_pkg::alu_op_e   dec_alu_op,
	input  logic [2:0]         dec_funct3,
	input  cpu_pkg::reg_addr_t rs1,
	input  cpu_pkg::reg_addr_t rs2,
	input  cpu_pkg::word_t     rdata1,
	input  cpu_pkg::word_t     rdata2,
	output cpu_pkg::reg_addr_t ex_rs1,
	output cpu_pkg::reg_addr_t ex_rs2,
	output logic               redirect,
	output cpu_pkg::word_t     redirect_pc,
	output logic               wb_valid,
	output logic               wb_wen,
	output cpu_pkg::reg_addr_t wb_rd,
	output cpu_pkg::word_t     wb_data,
	output cpu_pkg::word_t     wb_pc
);

	logic               ex_valid;
	cpu_pkg::op_class_e ex_class;
	cpu_pkg::alu_op_e   ex_alu_op;
	logic [2:0]         ex_funct3;
	cpu_pkg::word_t     ex_pc;
	cpu_pkg::word_t     ex_imm;
	cpu_pkg::reg_addr_t ex_rd;
	cpu_pkg::word_t     ex_rdata1;
	cpu_pkg::word_t     ex_rdata2;
	cpu_pkg::word_t     src_a;
	cpu_pkg::word_t     src_b;
	cpu_pkg::word_t     alu_a;
	cpu_pkg::word_t     alu_b;
	cpu_pkg::word_t     alu_result;
	cpu_pkg::word_t     ex_result;
	logic               alu_zero;
	logic               taken;
	logic               is_jump;
	logic               ex_wen;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_class <= cpu_pkg::none;
		end else if (advance) begin
			ex_valid <= dec_valid && !flush;
			ex_class <= flush ? cpu_pkg::none : dec_class;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_alu_op <= dec_alu_op;
			ex_funct3 <= dec_funct3;
			ex_pc <= dec_pc;
			ex_imm <= dec_imm;
			ex_rd <= dec_rd;
			ex_rs1 <= flush ? 5'd0 : rs1;
			ex_rs2 <= flush ? 5'd0 : rs2;
			ex_rdata1 <= rdata1;
			ex_rdata2 <= rdata2;
		end
	end

	// write-back value overrides the stale register read
	assign src_a = fwd_a ? wb_data : ex_rdata1;
	assign src_b = fwd_b ? wb_data : ex_rdata2;

	assign alu_a = (ex_class inside {cpu_pkg::auipc, cpu_pkg::jal}) ? ex_pc : src_a;
	assign alu_b = (ex_class inside {cpu_pkg::alu_reg, cpu_pkg::branch}) ? src_b : ex_imm;

	alu alu_inst (
		.a      (alu_a),
		.b      (alu_b),
		.op     (ex_alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	always_comb begin
		case (ex_funct3)
			3'b000: taken = alu_zero;
			3'b001: taken = !alu_zero;
			3'b100, 3'b110: taken = alu_result[0];
			3'b101, 3'b111: taken = !alu_result[0];
			default: taken = 1'b0;
		endcase
	end

	assign is_jump = (ex_class == cpu_pkg::jal) || (ex_class == cpu_pkg::jalr);
	assign redirect = ex_valid && (is_jump || (ex_class == cpu_pkg::branch && taken));
	// no misaligned fetch trap, so jump targets drop the low bits
	assign redirect_pc = is_jump ? {alu_result[31:2], 2'b00} : ex_pc + ex_imm;

	always_comb begin
		if (ex_class == cpu_pkg::lui) begin
			ex_result = ex_imm;
		end else if (is_jump) begin
			ex_result = ex_pc + 32'd4;
		end else begin
			ex_result = alu_result;
		end
	end

	assign ex_wen = ex_valid && !(ex_class inside {cpu_pkg::branch, cpu_pkg::none});

	// wb_valid pulses once per retire, wb_wen stays for forwarding
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_wen <= 1'b0;
		end else begin
			wb_valid <= advance && ex_valid;
			if (advance) begin
				wb_wen <= ex_wen;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_rd <= ex_rd;
			wb_data <= ex_result;
			wb_pc <= ex_pc;
		end
	end

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                advance,
	input  logic                flush,
	input  cpu_pkg::word_t      fetch_pc,
	input  cpu_pkg::word_t      fetch_instr,
	output cpu_pkg::reg_addr_t  rs1,
	output cpu_pkg::reg_addr_t  rs2,
	output logic                dec_valid,
	output cpu_pkg::word_t      dec_pc,
	output cpu_pkg::word_t      dec_imm,
	output cpu_pkg::reg_addr_t  dec_rd,
	output cpu_pkg::op_class_e  dec_class,
	output cpu_pkg::alu_op_e    dec_alu_op,
	output logic [2:0]          dec_funct3
);

	cpu_pkg::word_t   instr;
	cpu_pkg::opcode_e opcode;
	logic [6:0]       funct7;
	logic [2:0]       funct3;
	cpu_pkg::word_t   imm_i;
	cpu_pkg::word_t   imm_b;
	cpu_pkg::word_t   imm_u;
	cpu_pkg::word_t   imm_j;

	// shared by register and immediate forms
	function automatic cpu_pkg::alu_op_e alu_func(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? cpu_pkg::sub : cpu_pkg::add;
			3'b001: return cpu_pkg::sll;
			3'b010: return cpu_pkg::slt;
			3'b011: return cpu_pkg::sltu;
			3'b100: return cpu_pkg::xor_op;
			3'b101: return alt ? cpu_pkg::sra : cpu_pkg::srl;
			3'b110: return cpu_pkg::or_op;
			default: return cpu_pkg::and_op;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			instr <= cpu_pkg::NOP_INSTR;
		end else if (advance) begin
			dec_valid <= !flush;
			instr <= flush ? cpu_pkg::NOP_INSTR : fetch_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			dec_pc <= fetch_pc;
		end
	end

	assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign dec_rd = instr[11:7];
	assign dec_funct3 = funct3;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec_class = cpu_pkg::none;
		dec_alu_op = cpu_pkg::add;
		dec_imm = imm_i;
		case (opcode)
			cpu_pkg::OP: begin
				if (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 inside {3'b000, 3'b101})) begin
					dec_class = cpu_pkg::alu_reg;
					dec_alu_op = alu_func(funct3, funct7[5]);
				end
			end
			cpu_pkg::OP_IMM: begin
				// shift immediates carry funct7 in the upper immediate bits
				if ((funct3 != 3'b001 || funct7 == 7'h00) &&
						(funct3 != 3'b101 || funct7 == 7'h00 || funct7 == 7'h20)) begin
					dec_class = cpu_pkg::alu_imm;
					dec_alu_op = alu_func(funct3, funct3 == 3'b101 && funct7[5]);
				end
			end
			cpu_pkg::LUI: begin
				dec_class = cpu_pkg::lui;
				dec_imm = imm_u;
			end
			cpu_pkg::AUIPC: begin
				dec_class = cpu_pkg::auipc;
				dec_imm = imm_u;
			end
			cpu_pkg::BRANCH: begin
				if (funct3[2:1] != 2'b01) begin
					dec_class = cpu_pkg::branch;
					dec_imm = imm_b;
					// compare via sub for eq/ne, slt/sltu for the rest
					if (!funct3[2]) begin
						dec_alu_op = cpu_pkg::sub;
					end else begin
						dec_alu_op = funct3[1] ? cpu_pkg::sltu : cpu_pkg::slt;
					end
				end
			end
			cpu_pkg::JAL: begin
				dec_class = cpu_pkg::jal;
				dec_imm = imm_j;
			end
			cpu_pkg::JALR: begin
				if (funct3 == 3'b000) begin
					dec_class = cpu_pkg::jalr;
				end
			end
			default: begin
				dec_class = cpu_pkg::none;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           advance,
	input  logic           redirect,
	input  cpu_pkg::word_t redirect_pc,
	output logic           inst_req_valid,
	output cpu_pkg::word_t inst_req_pc,
	input  logic           inst_req_ready,
	input  logic           inst_resp_valid,
	input  cpu_pkg::word_t inst_resp_data,
	output logic           inst_resp_ready,
	output logic           inst_held,
	output cpu_pkg::word_t fetch_pc,
	output cpu_pkg::word_t fetch_instr
);

	typedef enum logic [1:0] {
		request,
		wait_response,
		holding,
		discard
	} fetch_state_e;

	fetch_state_e   state;
	cpu_pkg::word_t pc;
	cpu_pkg::word_t instr_q;
	logic           running;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= request;
			pc <= RESET_PC;
			running <= 1'b0;
		end else begin
			// first request goes out one cycle after reset is released
			running <= 1'b1;
			case (state)
				request: begin
					if (inst_req_valid && inst_req_ready) begin
						state <= wait_response;
					end
				end
				wait_response: begin
					// word fetched on the wrong path is kept only as a bubble
					if (inst_resp_valid) begin
						state <= redirect ? discard : holding;
					end
				end
				default: begin
					if (advance) begin
						state <= request;
						pc <= redirect ? redirect_pc : pc + 32'd4;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_resp_valid && inst_resp_ready) begin
			instr_q <= inst_resp_data;
		end
	end

	assign inst_req_valid = running && (state == request);
	assign inst_req_pc = pc;
	assign inst_resp_ready = (state == wait_response);
	assign inst_held = (state == holding) || (state == discard);
	assign fetch_pc = pc;
	assign fetch_instr = (state == discard) ? cpu_pkg::NOP_INSTR : instr_q;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic               clk,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  cpu_pkg::reg_addr_t waddr,
	input  logic               wen,
	input  cpu_pkg::word_t     wdata,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2
);

	cpu_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads zero and a same-cycle write is bypassed to the reader
	assign rdata1 = (raddr1 == 5'd0) ? '0 :
		(wen && raddr1 == waddr) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 :
		(wen && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t   result,
	output logic             zero
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			cpu_pkg::add: result = a + b;
			cpu_pkg::sub: result = a - b;
			cpu_pkg::sll: result = a << shamt;
			cpu_pkg::slt: result = {{(cpu_pkg::XLEN-1){1'b0}}, lt_signed};
			cpu_pkg::sltu: result = {{(cpu_pkg::XLEN-1){1'b0}}, lt_unsigned};
			cpu_pkg::xor_op: result = a ^ b;
			cpu_pkg::srl: result = a >> shamt;
			cpu_pkg::sra: result = $signed(a) >>> shamt;
			cpu_pkg::or_op: result = a | b;
			cpu_pkg::and_op: result = a & b;
			default: result = a + b;
		endcase
	end

	// eq/ne branches look at this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes handled by this core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

	// none also covers encodings the core does not support
	typedef enum logic [2:0] {
		alu_reg,
		alu_imm,
		lui,
		auipc,
		branch,
		jal,
		jalr,
		none
	} op_class_e;

	typedef enum logic [3:0] {
		add,
		sub,
		sll,
		slt,
		sltu,
		xor_op,
		srl,
		sra,
		or_op,
		and_op
	} alu_op_e;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
